// ==== rtl/masku_pkg.sv ====
//////////////////////////////
// Mask unit package
// Datapath widths, register file address layout, mask-logical
// opcodes and the operand slot order of the lane interface
//////////////////////////////

package masku_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Lane datapath width
  localparam int unsigned ElenBits     = 64;
  // vl and element counters, covers vl up to 1024
  localparam int unsigned VlWidth      = 11;
  // Beat index inside a destination register
  localparam int unsigned BeatIdxWidth = 4;

  // Operand slots per lane
  localparam int unsigned NrOpnd   = 4;
  localparam int          OpndVs2  = 0;
  localparam int          OpndVs1  = 1;
  localparam int          OpndVd   = 2;
  localparam int          OpndMask = 3;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [ElenBits-1:0] elen_t;
  typedef logic [VlWidth-1:0]  vl_t;
  typedef logic [4:0]          vreg_t;
  typedef logic [1:0]          vid_t;
  // Register file address, vd number above the beat index
  typedef logic [$bits(vreg_t)+BeatIdxWidth-1:0] vaddr_t;

  // Mask-logical operations, vd = f(vs2, vs1)
  typedef enum logic [2:0] {
    VMANDNOT = 3'd0,
    VMAND    = 3'd1,
    VMOR     = 3'd2,
    VMXOR    = 3'd3,
    VMORNOT  = 3'd4,
    VMNAND   = 3'd5,
    VMNOR    = 3'd6,
    VMXNOR   = 3'd7
  } mask_op_e;

endpackage

// ==== rtl/masku_insn_ctrl.sv ====
//////////////////////////////
// Mask unit instruction control
// Holds one instruction, tracks issued and committed beats
// and pulses done with the instruction id
//////////////////////////////

`timescale 1ns/1ps

module masku_insn_ctrl import masku_pkg::*; #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Sequencer request
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  mask_op_e                req_op_i,
  input  vl_t                     req_vl_i,
  input  vreg_t                   req_vd_i,
  input  logic                    req_vm_i,
  input  vid_t                    req_id_i,
  output logic                    done_o,
  output vid_t                    done_id_o,
  // Datapath events
  input  logic                    beat_fire_i,
  input  logic                    rq_pop_i,
  // Held instruction
  output logic                    issue_active_o,
  output mask_op_e                insn_op_o,
  output logic                    insn_vm_o,
  output vid_t                    insn_id_o,
  output vreg_t                   insn_vd_o,
  output logic [BeatIdxWidth-1:0] issue_beat_o,
  output vl_t                     issue_remain_o
);

  // Mask bits covered by one beat over all lanes
  localparam int unsigned BeatBits  = NrLanes * ElenBits;
  localparam int unsigned BeatShift = $clog2(BeatBits);
  // Up to 16 beats with a single lane
  localparam int unsigned CntWidth  = BeatIdxWidth + 1;

  logic                    held_d, held_q;
  logic                    done_d, done_q;
  vl_t                     remain_d, remain_q;
  logic [BeatIdxWidth-1:0] beat_d, beat_q;
  logic [CntWidth-1:0]     commit_d, commit_q;
  mask_op_e                op_q;
  logic                    vm_q;
  vid_t                    id_q;
  vreg_t                   vd_q;
  logic                    accept;
  logic [VlWidth:0]        vl_round;
  logic [CntWidth-1:0]     nr_beats;

  // One instruction at a time
  assign req_ready_o = ~held_q;
  assign accept      = req_valid_i & req_ready_o;

  // Beats = ceil(vl / BeatBits)
  assign vl_round = {1'b0, req_vl_i} + (VlWidth+1)'(BeatBits - 1);
  assign nr_beats = CntWidth'(vl_round >> BeatShift);

  //////////////////////////////
  // Counters
  //////////////////////////////

  always_comb begin
    held_d   = held_q;
    remain_d = remain_q;
    beat_d   = beat_q;
    commit_d = commit_q;

    if (accept) begin
      held_d   = 1'b1;
      remain_d = req_vl_i;
      beat_d   = '0;
      commit_d = nr_beats;
    end

    // Issue side walks over the elements
    if (beat_fire_i) begin
      if (remain_q >= vl_t'(BeatBits)) begin
        remain_d = remain_q - vl_t'(BeatBits);
      end else begin
        remain_d = '0;
      end
      beat_d = beat_q + 1'b1;
    end

    // Commit side counts retired beats
    if (rq_pop_i) begin
      commit_d = commit_q - 1'b1;
    end

    // Last beat written back, release the instruction
    done_d = held_q && (commit_d == '0);
    if (done_d) begin
      held_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q   <= 1'b0;
      done_q   <= 1'b0;
      remain_q <= '0;
      beat_q   <= '0;
      commit_q <= '0;
    end else begin
      held_q   <= held_d;
      done_q   <= done_d;
      remain_q <= remain_d;
      beat_q   <= beat_d;
      commit_q <= commit_d;
    end
  end

  // Instruction payload, captured on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= req_op_i;
      vm_q <= req_vm_i;
      id_q <= req_id_i;
      vd_q <= req_vd_i;
    end
  end

  assign issue_active_o = held_q && (remain_q != '0);
  assign insn_op_o      = op_q;
  assign insn_vm_o      = vm_q;
  assign insn_id_o      = id_q;
  assign insn_vd_o      = vd_q;
  assign issue_beat_o   = beat_q;
  assign issue_remain_o = remain_q;
  // id_q is stable until the next acceptance
  assign done_o         = done_q;
  assign done_id_o      = id_q;

endmodule

// ==== rtl/masku_logic_alu.sv ====
//////////////////////////////
// Mask unit logic ALU
// Joins lane operands, builds the active-bit enable
// and merges the mask-logical result with the old vd
//////////////////////////////

`timescale 1ns/1ps

module masku_logic_alu import masku_pkg::*; #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                    issue_active_i,
  input  mask_op_e                insn_op_i,
  input  logic                    insn_vm_i,
  input  vid_t                    insn_id_i,
  input  vreg_t                   insn_vd_i,
  input  logic [BeatIdxWidth-1:0] issue_beat_i,
  input  vl_t                     issue_remain_i,
  // Lane operands
  input  elen_t                   opnd_i       [NrLanes][NrOpnd],
  input  logic                    opnd_valid_i [NrLanes][NrOpnd],
  output logic                    opnd_ready_o [NrLanes][NrOpnd],
  // Result queue
  input  logic                    rq_full_i,
  output logic                    beat_fire_o,
  output logic                    res_push_o,
  output elen_t                   res_data_o   [NrLanes],
  output vaddr_t                  res_addr_o,
  output vid_t                    res_id_o
);

  localparam int unsigned BeatBits = NrLanes * ElenBits;

  logic                all_valid;
  logic [BeatBits-1:0] vl_en;

  // Every lane needs vs2, vs1 and vd, plus v0 when masked
  always_comb begin
    all_valid = 1'b1;
    for (int l = 0; l < NrLanes; l++) begin
      all_valid &= opnd_valid_i[l][OpndVs2] & opnd_valid_i[l][OpndVs1];
      all_valid &= opnd_valid_i[l][OpndVd];
      all_valid &= insn_vm_i | opnd_valid_i[l][OpndMask];
    end
  end

  assign beat_fire_o = issue_active_i & ~rq_full_i & all_valid;
  assign res_push_o  = beat_fire_o;

  // Tail enable, bits below the remaining element count
  always_comb begin
    if (issue_remain_i >= vl_t'(BeatBits)) begin
      vl_en = '1;
    end else begin
      vl_en = (BeatBits'(1) << issue_remain_i) - BeatBits'(1);
    end
  end

  //////////////////////////////
  // Per-lane datapath
  //////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    elen_t bit_en;
    elen_t op_res;

    // Flat layout, lane l holds bits l*64 up of the beat
    assign bit_en = vl_en[l*ElenBits +: ElenBits] &
                    (insn_vm_i ? '1 : opnd_i[l][OpndMask]);

    always_comb begin
      case (insn_op_i)
        VMAND:    op_res = opnd_i[l][OpndVs2] & opnd_i[l][OpndVs1];
        VMNAND:   op_res = ~(opnd_i[l][OpndVs2] & opnd_i[l][OpndVs1]);
        VMANDNOT: op_res = opnd_i[l][OpndVs2] & ~opnd_i[l][OpndVs1];
        VMXOR:    op_res = opnd_i[l][OpndVs2] ^ opnd_i[l][OpndVs1];
        VMOR:     op_res = opnd_i[l][OpndVs2] | opnd_i[l][OpndVs1];
        VMNOR:    op_res = ~(opnd_i[l][OpndVs2] | opnd_i[l][OpndVs1]);
        VMORNOT:  op_res = opnd_i[l][OpndVs2] | ~opnd_i[l][OpndVs1];
        default:  op_res = ~(opnd_i[l][OpndVs2] ^ opnd_i[l][OpndVs1]);
      endcase
    end

    // Inactive bits keep the old destination value
    assign res_data_o[l] = (op_res & bit_en) | (opnd_i[l][OpndVd] & ~bit_en);

    // Consume the beat, v0 only when it is used
    assign opnd_ready_o[l][OpndVs2]  = beat_fire_o;
    assign opnd_ready_o[l][OpndVs1]  = beat_fire_o;
    assign opnd_ready_o[l][OpndVd]   = beat_fire_o;
    assign opnd_ready_o[l][OpndMask] = beat_fire_o & ~insn_vm_i;
  end

  assign res_addr_o = {insn_vd_i, issue_beat_i};
  assign res_id_o   = insn_id_i;

endmodule

// ==== rtl/masku_result_queue.sv ====
//////////////////////////////
// Mask unit result queue
// Two entries shared by all lanes, each lane writes
// its word back with its own request/grant pair
//////////////////////////////

`timescale 1ns/1ps

module masku_result_queue import masku_pkg::*; #(
  parameter int unsigned NrLanes = 2
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  // Push from the ALU
  input  logic   res_push_i,
  input  elen_t  res_data_i [NrLanes],
  input  vaddr_t res_addr_i,
  input  vid_t   res_id_i,
  output logic   rq_full_o,
  output logic   rq_pop_o,
  // Register file write-back
  output logic   wr_req_o   [NrLanes],
  output vaddr_t wr_addr_o  [NrLanes],
  output elen_t  wr_data_o  [NrLanes],
  output vid_t   wr_id_o    [NrLanes],
  input  logic   wr_gnt_i   [NrLanes]
);

  localparam int unsigned Depth = 2;

  // Entry payload
  elen_t      data_q [Depth][NrLanes];
  vaddr_t     addr_q [Depth];
  vid_t       id_q   [Depth];
  // Lane still owes a write for this entry
  logic       pend_q [Depth][NrLanes];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] cnt_q;
  logic       head_done;

  //////////////////////////////
  // Status
  //////////////////////////////

  // Head retires once each lane was granted, this cycle or earlier
  always_comb begin
    head_done = 1'b1;
    for (int l = 0; l < NrLanes; l++) begin
      head_done &= ~pend_q[rd_ptr_q][l] | wr_gnt_i[l];
    end
  end

  assign rq_pop_o  = (cnt_q != 2'd0) && head_done;
  // Registered count, a pop in this cycle does not free a slot yet
  assign rq_full_o = (cnt_q == 2'(Depth));

  //////////////////////////////
  // Pointers and pending bits
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
      for (int e = 0; e < Depth; e++) begin
        for (int l = 0; l < NrLanes; l++) begin
          pend_q[e][l] <= 1'b0;
        end
      end
    end else begin
      // Granted lanes drop their request
      for (int l = 0; l < NrLanes; l++) begin
        if (wr_gnt_i[l]) begin
          pend_q[rd_ptr_q][l] <= 1'b0;
        end
      end
      // New entry requests on every lane from the next cycle
      if (res_push_i) begin
        for (int l = 0; l < NrLanes; l++) begin
          pend_q[wr_ptr_q][l] <= 1'b1;
        end
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (rq_pop_o) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      cnt_q <= cnt_q + 2'(res_push_i) - 2'(rq_pop_o);
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (res_push_i) begin
      for (int l = 0; l < NrLanes; l++) begin
        data_q[wr_ptr_q][l] <= res_data_i[l];
      end
      addr_q[wr_ptr_q] <= res_addr_i;
      id_q[wr_ptr_q]   <= res_id_i;
    end
  end

  // Head entry drives every lane
  for (genvar l = 0; l < NrLanes; l++) begin : gen_wr
    assign wr_req_o[l]  = pend_q[rd_ptr_q][l];
    assign wr_addr_o[l] = addr_q[rd_ptr_q];
    assign wr_data_o[l] = data_q[rd_ptr_q][l];
    assign wr_id_o[l]   = id_q[rd_ptr_q];
  end

endmodule

// ==== rtl/masku_top.sv ====
//////////////////////////////
// Mask unit top level
// Mask-logical instructions over all lanes
//////////////////////////////

`timescale 1ns/1ps

module masku_top import masku_pkg::*; #(
  parameter int unsigned NrLanes = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Sequencer
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  mask_op_e req_op_i,
  input  vl_t      req_vl_i,
  input  vreg_t    req_vd_i,
  input  logic     req_vm_i,
  input  vid_t     req_id_i,
  output logic     done_o,
  output vid_t     done_id_o,
  // Lane operands
  input  elen_t    opnd_i       [NrLanes][NrOpnd],
  input  logic     opnd_valid_i [NrLanes][NrOpnd],
  output logic     opnd_ready_o [NrLanes][NrOpnd],
  // Register file write-back
  output logic     wr_req_o     [NrLanes],
  output vaddr_t   wr_addr_o    [NrLanes],
  output elen_t    wr_data_o    [NrLanes],
  output vid_t     wr_id_o      [NrLanes],
  input  logic     wr_gnt_i     [NrLanes]
);

  // Control to ALU
  logic                    issue_active;
  mask_op_e                insn_op;
  logic                    insn_vm;
  vid_t                    insn_id;
  vreg_t                   insn_vd;
  logic [BeatIdxWidth-1:0] issue_beat;
  vl_t                     issue_remain;
  // ALU to queue and back
  logic                    beat_fire;
  logic                    res_push;
  elen_t                   res_data [NrLanes];
  vaddr_t                  res_addr;
  vid_t                    res_id;
  logic                    rq_full;
  logic                    rq_pop;

  masku_insn_ctrl #(
    .NrLanes (NrLanes)
  ) u_insn_ctrl (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_op_i, .req_vl_i, .req_vd_i, .req_vm_i, .req_id_i,
    .done_o, .done_id_o,
    .beat_fire_i    (beat_fire),
    .rq_pop_i       (rq_pop),
    .issue_active_o (issue_active),
    .insn_op_o      (insn_op),
    .insn_vm_o      (insn_vm),
    .insn_id_o      (insn_id),
    .insn_vd_o      (insn_vd),
    .issue_beat_o   (issue_beat),
    .issue_remain_o (issue_remain)
  );

  masku_logic_alu #(
    .NrLanes (NrLanes)
  ) u_logic_alu (
    .issue_active_i (issue_active),
    .insn_op_i      (insn_op),
    .insn_vm_i      (insn_vm),
    .insn_id_i      (insn_id),
    .insn_vd_i      (insn_vd),
    .issue_beat_i   (issue_beat),
    .issue_remain_i (issue_remain),
    .opnd_i, .opnd_valid_i, .opnd_ready_o,
    .rq_full_i      (rq_full),
    .beat_fire_o    (beat_fire),
    .res_push_o     (res_push),
    .res_data_o     (res_data),
    .res_addr_o     (res_addr),
    .res_id_o       (res_id)
  );

  masku_result_queue #(
    .NrLanes (NrLanes)
  ) u_result_queue (
    .clk_i, .rst_ni,
    .res_push_i (res_push),
    .res_data_i (res_data),
    .res_addr_i (res_addr),
    .res_id_i   (res_id),
    .rq_full_o  (rq_full),
    .rq_pop_o   (rq_pop),
    .wr_req_o, .wr_addr_o, .wr_data_o, .wr_id_o, .wr_gnt_i
  );

endmodule

// ==== dv/masku_asserts.sv ====
//////////////////////////////
// Mask unit checker
// Reference model of the result stream and
// handshake, enable and data assertions
//////////////////////////////

`timescale 1ns/1ps

module masku_asserts import masku_pkg::*; #(
  parameter int unsigned NrLanes = 2
) (
  input logic     clk_i,
  input logic     rst_ni,
  input logic     req_valid_i,
  input logic     req_ready_o,
  input mask_op_e req_op_i,
  input vl_t      req_vl_i,
  input vreg_t    req_vd_i,
  input logic     req_vm_i,
  input vid_t     req_id_i,
  input logic     done_o,
  input vid_t     done_id_o,
  input elen_t    opnd_i       [NrLanes][NrOpnd],
  input logic     opnd_valid_i [NrLanes][NrOpnd],
  input logic     opnd_ready_o [NrLanes][NrOpnd],
  input logic     wr_req_o     [NrLanes],
  input vaddr_t   wr_addr_o    [NrLanes],
  input elen_t    wr_data_o    [NrLanes],
  input vid_t     wr_id_o      [NrLanes],
  input logic     wr_gnt_i     [NrLanes]
);

  localparam int unsigned BeatBits = NrLanes * ElenBits;

  // Raised by every failing assertion, read by the testbench
  int unsigned fail_cnt = 0;

  // Accepted instruction
  logic        busy_q;
  mask_op_e    op_q;
  vl_t         vl_q;
  vreg_t       vd_q;
  logic        vm_q;
  vid_t        id_q;
  int unsigned beats_q;
  int unsigned exp_beats;
  // Expected result queue, two entries
  elen_t       exp_data [2][NrLanes];
  vaddr_t      exp_addr [2];
  vid_t        exp_id   [2];
  logic        wr_q, rd_q;
  int unsigned cnt_q;
  logic        got_q    [NrLanes];
  // Per-cycle events
  logic        accept, fire, pop, all_got, any_req, any_ready;
  elen_t       fire_word [NrLanes];

  // Logical operation on one bit pair
  function automatic logic op_bit(mask_op_e op, logic a, logic b);
    logic r;
    case (op)
      VMAND, VMNAND: r = a & b;
      VMOR, VMNOR:   r = a | b;
      VMXOR, VMXNOR: r = a ^ b;
      VMANDNOT:      r = a & ~b;
      default:       r = a | ~b;
    endcase
    if (op inside {VMNAND, VMNOR, VMXNOR}) begin
      r = ~r;
    end
    return r;
  endfunction

  assign accept    = req_valid_i & req_ready_o;
  // Ready on vs2 marks a consumed beat
  assign fire      = opnd_ready_o[0][OpndVs2];
  assign exp_beats = (int'(vl_q) + BeatBits - 1) / BeatBits;

  always_comb begin
    all_got   = 1'b1;
    any_req   = 1'b0;
    any_ready = 1'b0;
    for (int l = 0; l < NrLanes; l++) begin
      all_got &= got_q[l] | (wr_req_o[l] & wr_gnt_i[l]);
      any_req |= wr_req_o[l];
      for (int s = 0; s < NrOpnd; s++) begin
        any_ready |= opnd_ready_o[l][s];
      end
    end
    pop = (cnt_q != 0) && all_got;
  end

  // Element index of bit k, lane l, beat n is n*BeatBits + l*64 + k
  always_comb begin
    int  elem;
    logic act;
    for (int l = 0; l < NrLanes; l++) begin
      for (int k = 0; k < ElenBits; k++) begin
        elem = beats_q * BeatBits + l * ElenBits + k;
        act  = (elem < int'(vl_q)) && (vm_q || opnd_i[l][OpndMask][k]);
        fire_word[l][k] = act ? op_bit(op_q, opnd_i[l][OpndVs2][k], opnd_i[l][OpndVs1][k])
                              : opnd_i[l][OpndVd][k];
      end
    end
  end

  //////////////////////////////
  // Model state
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      beats_q <= 0;
      wr_q    <= 1'b0;
      rd_q    <= 1'b0;
      cnt_q   <= 0;
      for (int l = 0; l < NrLanes; l++) begin
        got_q[l] <= 1'b0;
      end
    end else begin
      if (done_o) begin
        busy_q <= 1'b0;
      end
      // A new instruction may be accepted in the done cycle
      if (accept) begin
        busy_q  <= 1'b1;
        beats_q <= 0;
      end
      if (fire) begin
        beats_q <= beats_q + 1;
        wr_q    <= ~wr_q;
      end
      for (int l = 0; l < NrLanes; l++) begin
        if (pop) begin
          got_q[l] <= 1'b0;
        end else if (wr_req_o[l] && wr_gnt_i[l]) begin
          got_q[l] <= 1'b1;
        end
      end
      if (pop) begin
        rd_q <= ~rd_q;
      end
      cnt_q <= cnt_q + int'(fire) - int'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= req_op_i;
      vl_q <= req_vl_i;
      vd_q <= req_vd_i;
      vm_q <= req_vm_i;
      id_q <= req_id_i;
    end
    if (fire) begin
      exp_data[wr_q] <= fire_word;
      exp_addr[wr_q] <= {vd_q, BeatIdxWidth'(beats_q)};
      exp_id[wr_q]   <= id_q;
    end
  end

  //////////////////////////////
  // Sequencer side
  //////////////////////////////

  a_reset_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(rst_ni) |-> req_ready_o && !done_o && !any_req && !any_ready)
    else begin
      $error("Outputs are not idle after reset");
      fail_cnt++;
    end

  a_accept_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> !req_ready_o)
    else begin
      $error("Request ready stayed high after an acceptance");
      fail_cnt++;
    end

  a_ready_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(req_ready_o) |-> done_o)
    else begin
      $error("Request ready rose without a done pulse");
      fail_cnt++;
    end

  a_done_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> done_id_o == id_q)
    else begin
      $error("Mismatch done_id_o: got %h expected %h", $sampled(done_id_o), $sampled(id_q));
      fail_cnt++;
    end

  a_done_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> busy_q && cnt_q == 0 && !any_req)
    else begin
      $error("Done raised with no instruction or with results still pending");
      fail_cnt++;
    end

  a_beat_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> beats_q == exp_beats)
    else begin
      $error("Mismatch beat count: got %h expected %h", $sampled(beats_q), $sampled(exp_beats));
      fail_cnt++;
    end

  // Beats only inside an accepted instruction
  a_beat_window: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fire |-> busy_q && beats_q < exp_beats)
    else begin
      $error("Operand beat consumed with no instruction or beyond the last beat");
      fail_cnt++;
    end

  // Two unpopped entries stall every operand slot
  a_full_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q == 2 |-> !any_ready)
    else begin
      $error("Operand consumed while the result queue was full");
      fail_cnt++;
    end

  //////////////////////////////
  // Lane side
  //////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    // All lanes take vs2, vs1 and vd together, v0 only when masked
    a_beat_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
      opnd_ready_o[l][OpndVs2] == fire && opnd_ready_o[l][OpndVs1] == fire &&
      opnd_ready_o[l][OpndVd] == fire && opnd_ready_o[l][OpndMask] == (fire && !vm_q))
      else begin
        $error("Operand ready of lane %0d does not follow the consumed beat", l);
        fail_cnt++;
      end

    a_beat_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fire |-> opnd_valid_i[l][OpndVs2] && opnd_valid_i[l][OpndVs1] &&
               opnd_valid_i[l][OpndVd] && (vm_q || opnd_valid_i[l][OpndMask]))
      else begin
        $error("Beat consumed while an operand of lane %0d was not valid", l);
        fail_cnt++;
      end

    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wr_req_o[l] && !wr_gnt_i[l] |=> wr_req_o[l] && $stable(wr_data_o[l]) &&
                                       $stable(wr_addr_o[l]) && $stable(wr_id_o[l]))
      else begin
        $error("Write request of lane %0d dropped or changed before its grant", l);
        fail_cnt++;
      end

    a_wr_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wr_req_o[l] && wr_gnt_i[l] |-> cnt_q != 0 && wr_data_o[l] == exp_data[rd_q][l])
      else begin
        $error("Mismatch wr_data_o[%0d]: got %h expected %h", l,
               $sampled(wr_data_o[l]), $sampled(exp_data[rd_q][l]));
        fail_cnt++;
      end

    a_wr_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wr_req_o[l] && wr_gnt_i[l] |-> wr_addr_o[l] == exp_addr[rd_q])
      else begin
        $error("Mismatch wr_addr_o[%0d]: got %h expected %h", l,
               $sampled(wr_addr_o[l]), $sampled(exp_addr[rd_q]));
        fail_cnt++;
      end

    a_wr_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wr_req_o[l] && wr_gnt_i[l] |-> wr_id_o[l] == exp_id[rd_q])
      else begin
        $error("Mismatch wr_id_o[%0d]: got %h expected %h", l,
               $sampled(wr_id_o[l]), $sampled(exp_id[rd_q]));
        fail_cnt++;
      end

    // v0 is left alone by unmasked instructions
    a_mask_unused: assert property (@(posedge clk_i) disable iff (!rst_ni)
      busy_q && vm_q |-> !opnd_ready_o[l][OpndMask])
      else begin
        $error("Mask slot of lane %0d consumed by an unmasked instruction", l);
        fail_cnt++;
      end
  end

endmodule

bind masku_top masku_asserts #(.NrLanes(NrLanes)) u_asserts (.*);

// ==== dv/tb_masku.sv ====
//////////////////////////////
// Mask unit testbench
// Sequencer, lane operand and register file stimulus
// around the mask unit, checking lives in the bound asserts
//////////////////////////////

`timescale 1ns/1ps

module tb_masku import masku_pkg::*; ();

  localparam int unsigned NrLanes       = 2;
  localparam int unsigned TimeoutCycles = 2000;

  logic     clk_i;
  logic     rst_ni;
  logic     req_valid_i;
  logic     req_ready_o;
  mask_op_e req_op_i;
  vl_t      req_vl_i;
  vreg_t    req_vd_i;
  logic     req_vm_i;
  vid_t     req_id_i;
  logic     done_o;
  vid_t     done_id_o;
  elen_t    opnd_i       [NrLanes][NrOpnd];
  logic     opnd_valid_i [NrLanes][NrOpnd];
  logic     opnd_ready_o [NrLanes][NrOpnd];
  logic     wr_req_o     [NrLanes];
  vaddr_t   wr_addr_o    [NrLanes];
  elen_t    wr_data_o    [NrLanes];
  vid_t     wr_id_o      [NrLanes];
  logic     wr_gnt_i     [NrLanes];

  integer      seed;
  int unsigned timeout_cnt;
  int unsigned error_cnt;
  vid_t        next_id;
  vreg_t       next_vd;
  // Slots consumed on the last rising edge
  logic        taken_q [NrLanes][NrOpnd];

  masku_top #(
    .NrLanes (NrLanes)
  ) u_dut (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_op_i, .req_vl_i, .req_vd_i, .req_vm_i, .req_id_i,
    .done_o, .done_id_o,
    .opnd_i, .opnd_valid_i, .opnd_ready_o,
    .wr_req_o, .wr_addr_o, .wr_data_o, .wr_id_o, .wr_gnt_i
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Lane and write-back stimulus
  //////////////////////////////

  always @(posedge clk_i) begin
    taken_q <= opnd_ready_o;
  end

  // New operand only once the old one was taken or never offered
  always @(negedge clk_i) begin
    if (rst_ni) begin
      for (int l = 0; l < NrLanes; l++) begin
        for (int s = 0; s < NrOpnd; s++) begin
          if (!opnd_valid_i[l][s] || taken_q[l][s]) begin
            opnd_valid_i[l][s] = ($random(seed) & 3) != 0;
            opnd_i[l][s]       = {$random(seed), $random(seed)};
          end
        end
        // Random back-pressure per lane
        wr_gnt_i[l] = wr_req_o[l] && (($random(seed) & 1) != 0);
      end
    end
  end

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  // Offer one instruction and hold it until accepted
  task automatic send_request(input mask_op_e op, input vl_t vl, input logic vm);
    int unsigned wait_cnt;
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_vl_i    = vl;
    req_vd_i    = next_vd;
    req_vm_i    = vm;
    req_id_i    = next_id;
    wait_cnt    = 0;
    while (!req_ready_o && wait_cnt < TimeoutCycles) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (!req_ready_o) begin
      $display("Timeout: instruction %0d was never accepted", next_id);
      timeout_cnt++;
    end
    // Transfer on the rising edge in between
    @(negedge clk_i);
    req_valid_i = 1'b0;
    next_id     = next_id + 1'b1;
    next_vd     = next_vd + 5'd3;
  endtask

  task automatic wait_done();
    int unsigned wait_cnt;
    wait_cnt = 0;
    do begin
      @(negedge clk_i);
      wait_cnt++;
    end while (!done_o && wait_cnt < TimeoutCycles);
    if (!done_o) begin
      $display("Timeout: no done pulse for the instruction in flight");
      timeout_cnt++;
    end
  endtask

  task automatic run_insn(input mask_op_e op, input vl_t vl, input logic vm);
    send_request(op, vl, vm);
    wait_done();
  endtask

  initial begin
    seed        = 32'hc1c7_c978;
    timeout_cnt = 0;
    next_id     = '0;
    next_vd     = 5'd1;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = VMAND;
    req_vl_i    = '0;
    req_vd_i    = '0;
    req_vm_i    = 1'b1;
    req_id_i    = '0;
    for (int l = 0; l < NrLanes; l++) begin
      wr_gnt_i[l] = 1'b0;
      for (int s = 0; s < NrOpnd; s++) begin
        opnd_i[l][s]       = '0;
        opnd_valid_i[l][s] = 1'b0;
      end
    end

    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (3) @(negedge clk_i);

    // Every operation over whole beats, unmasked
    for (int op = 0; op < 8; op++) begin
      run_insn(mask_op_e'(op), vl_t'(256), 1'b1);
    end
    // Tails inside a beat
    run_insn(VMXOR, vl_t'(200), 1'b1);
    run_insn(VMAND, vl_t'(77), 1'b1);
    // Masked, with and without a tail
    run_insn(VMOR, vl_t'(128), 1'b0);
    run_insn(VMNAND, vl_t'(1000), 1'b0);
    run_insn(VMXNOR, vl_t'(1024), 1'b0);
    run_insn(VMORNOT, vl_t'(3), 1'b0);
    run_insn(VMANDNOT, vl_t'(513), 1'b0);

    repeat (5) @(negedge clk_i);
    error_cnt = u_dut.u_asserts.fail_cnt + timeout_cnt;
    $display("Closing: %0d assertion failures, %0d timeouts",
             u_dut.u_asserts.fail_cnt, timeout_cnt);
    if (error_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== all.f ====
rtl/masku_pkg.sv
rtl/masku_insn_ctrl.sv
rtl/masku_logic_alu.sv
rtl/masku_result_queue.sv
rtl/masku_top.sv
dv/masku_asserts.sv
dv/tb_masku.sv

// ==== Bender.yml ====
package:
  name: masku

sources:
  # Design
  - files:
      - rtl/masku_pkg.sv
      - rtl/masku_insn_ctrl.sv
      - rtl/masku_logic_alu.sv
      - rtl/masku_result_queue.sv
      - rtl/masku_top.sv
  # Verification
  - target: test
    files:
      - dv/masku_asserts.sv
      - dv/tb_masku.sv
